// ==== list.f ====
bus_pkg.sv
bus_decode.sv
bus_resp_mux.sv
ram_blk.sv
tmr_blk.sv
bio_blk.sv
bus_top.sv
tb_clk.sv
tb_bus_asserts.sv
tb_bus.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run with Verilator, pass only if the pass message is seen
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert --top-module tb_bus -f list.f \
  && ./obj_dir/Vtb_bus | tee /dev/stderr | grep -qF "Simulation passed" \
  && echo "run ok" \
  || { echo "run failed"; exit 1; }

// ==== tb_bus.sv ====
//############################
// testbench top, cpu bus driver,
// ram model, checks and timeout
//############################
`timescale 1ns/1ns

module tb_bus;
  import bus_pkg::*;

  localparam int CYC_LIMIT = 4000;

  logic        clk;
  logic        arst_n;
  bus_req_t    req;
  bus_rsp_t    rsp;
  logic        irq;
  logic [15:0] sw;
  logic [15:0] led;
  bus_data_t   ram_model [RAM_WORDS];
  logic [31:0] rnd_state = 32'h84e59b37;
  int          cyc = 0;
  int          chk_cnt = 0;
  int          err_cnt = 0;

  tb_clk u_clk (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  bus_top uut (
    .i_clk    (clk),
    .i_arst_n (arst_n),
    .i_req    (req),
    .o_rsp    (rsp),
    .o_irq    (irq),
    .i_sw     (sw),
    .o_led    (led)
  );

  function automatic logic [31:0] lcg_next();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  // byte lanes from size and the low address bits
  function automatic bus_data_t merge_lanes(bus_data_t old, bus_size_t size,
                                            logic [1:0] lo, bus_data_t wd);
    bus_data_t res;
    res = old;
    case (size)
      SIZE_BYTE: res[8*lo +: 8] = wd[7:0];
      SIZE_HALF: res[16*lo[1] +: 16] = wd[15:0];
      default:   res = wd;
    endcase
    return res;
  endfunction

  // called just after a falling edge, returns just after one
  task automatic bus_xfer(input logic wr, input bus_size_t size, input bus_addr_t addr,
                          input bus_data_t wd, output bus_data_t rd, output int waits);
    logic done;
    done  = 1'b0;
    waits = 0;
    rd    = '0;
    req   = '{en: 1'b1, wr: wr, size: size, addr: addr, wdata: wd};
    while (!done) begin
      #1;
      if (rsp.wt) begin
        waits++;
      end else begin
        done = 1'b1;
        rd   = rsp.rdata;
      end
      @(negedge clk);
    end
    req.en = 1'b0;
    req.wr = 1'b0;
  endtask

  task automatic bus_write(input bus_size_t size, input bus_addr_t addr, input bus_data_t wd);
    bus_data_t rd;
    int        waits;
    bus_xfer(1'b1, size, addr, wd, rd, waits);
    if (addr[31:25] == 7'd0) begin
      ram_model[addr[RAM_AW+1:2]] = merge_lanes(ram_model[addr[RAM_AW+1:2]], size,
                                                addr[1:0], wd);
    end
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t rd);
    int waits;
    bus_xfer(1'b0, SIZE_WORD, addr, '0, rd, waits);
  endtask

  task automatic check_val(input string name, input bus_data_t exp, input bus_data_t got);
    chk_cnt++;
    assert (got == exp) else begin
      $display("ERR %s exp=%h got=%h", name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic check_ram(input bus_addr_t addr);
    bus_data_t rd;
    int        waits;
    bus_xfer(1'b0, SIZE_WORD, addr, '0, rd, waits);
    check_val("ram rdata", ram_model[addr[RAM_AW+1:2]], rd);
    check_val("ram wait", 32'd1, waits);
  endtask

  always @(posedge clk) begin
    cyc++;
    if (cyc >= CYC_LIMIT) begin
      $display("timeout, run did not finish within %0d cycles", CYC_LIMIT);
      $display("checks: %0d errors: %0d", chk_cnt, err_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    bus_data_t   rd;
    bus_data_t   d;
    bus_addr_t   a;
    bus_addr_t   addrs [40];
    bus_addr_t   unmapped [3];
    logic [15:0] led_exp;
    int          waits;
    int          t_wr;
    logic        seen;
    req      = '0;
    sw       = '0;
    led_exp  = '0;
    unmapped = '{32'h0200_0000, 32'h3000_1004, 32'h2000_0000};
    wait (arst_n === 1'b1);
    @(negedge clk);

    // random words, all written first then read back
    foreach (addrs[i]) begin
      a        = lcg_next();
      addrs[i] = {7'd0, a[24:2], 2'b00};
      bus_write(SIZE_WORD, addrs[i], lcg_next());
    end
    foreach (addrs[i]) begin
      check_ram(addrs[i]);
    end

    // byte and half merges over a known word
    for (int i = 0; i < 20; i++) begin
      a = lcg_next();
      a = {7'd0, a[24:0]};
      bus_write(SIZE_WORD, {a[31:2], 2'b00}, lcg_next());
      bus_write(bus_size_t'(i % 2), a, lcg_next());
      check_ram(a);
    end

    // timer, irq enable then divisor 5
    bus_write(SIZE_WORD, 32'h3000_0000, 32'd1);
    bus_write(SIZE_WORD, 32'h3000_0004, 32'd5);
    t_wr = cyc;
    seen = 1'b0;
    for (int i = 0; i < 20 && !seen; i++) begin
      bus_read(32'h3000_0000, rd);
      seen = rd[1];
    end
    if (!seen) begin
      $display("timer expired flag never set within 20 reads");
      err_cnt++;
    end
    chk_cnt++;
    assert (cyc - t_wr - 1 >= 5) else begin
      $display("ERR tmr expiry delay exp>=%h got=%h", 5, cyc - t_wr - 1);
      err_cnt++;
    end
    check_val("o_irq", 32'd1, {31'd0, irq});
    for (int i = 0; i < 8; i++) begin
      bus_read(32'h3000_0008, rd);
      chk_cnt++;
      assert (rd <= 32'd5) else begin
        $display("ERR tmr cnt exp<=%h got=%h", 32'd5, rd);
        err_cnt++;
      end
    end
    // stop the counter, then clear the flag
    bus_write(SIZE_WORD, 32'h3000_0004, 32'd0);
    bus_write(SIZE_WORD, 32'h3000_0000, 32'd1);
    @(negedge clk);
    check_val("o_irq", 32'd0, {31'd0, irq});

    // board i/o
    for (int i = 0; i < 5; i++) begin
      d       = lcg_next();
      led_exp = d[15:0];
      bus_write(SIZE_WORD, 32'h3100_0000, d);
      check_val("o_led", {16'd0, led_exp}, {16'd0, led});
      bus_read(32'h3100_0000, rd);
      check_val("led rdata", {16'd0, led_exp}, rd);
      d  = lcg_next();
      sw = d[31:16];
      bus_read(32'h3100_0004, rd);
      check_val("sw rdata", {16'd0, d[31:16]}, rd);
    end

    // unmapped reads and writes
    bus_write(SIZE_WORD, 32'h0000_0000, 32'h1234_5678);
    foreach (unmapped[i]) begin
      bus_xfer(1'b0, SIZE_WORD, unmapped[i], '0, rd, waits);
      check_val("unmapped rdata", 32'd0, rd);
      check_val("unmapped wait", 32'd0, waits);
      bus_write(SIZE_WORD, unmapped[i], lcg_next());
    end
    check_ram(32'h0000_0000);
    bus_read(32'h3000_0004, rd);
    check_val("tmr div", 32'd0, rd);
    check_val("o_led", {16'd0, led_exp}, {16'd0, led});

    $display("checks: %0d errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tb_bus_asserts.sv ====
//############################
// bound bus protocol assertions
//############################
`timescale 1ns/1ns

module tb_bus_asserts (
  input logic              i_clk,
  input logic              i_arst_n,
  input bus_pkg::bus_req_t i_req,
  input bus_pkg::bus_rsp_t i_rsp,
  input bus_pkg::dev_sel_t i_sel,
  input logic              i_irq
);
  import bus_pkg::*;

  logic ram_rd;
  logic map_hit;
  logic ctrl_clr;

  assign ram_rd   = i_sel.ram && !i_req.wr;
  // address falls in the ram, timer or board i/o window
  assign map_hit  = (i_req.addr[31:25] == 7'd0)
                 || ((i_req.addr[31:20] == TMR_BASE_HI) && (i_req.addr[19:12] == 8'h00))
                 || (i_req.addr[31:20] == BIO_BASE_HI);
  // write of 0 to the expired bit
  assign ctrl_clr = i_sel.tmr && i_req.wr && (i_req.addr[3:2] == TMR_CTRL) && !i_req.wdata[1];

  one_select: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $onehot0({i_sel.ram, i_sel.tmr, i_sel.bio}))
    else $error("more than one device selected");

  unmapped_zero: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_req.en && !map_hit |-> !i_rsp.wt && (i_rsp.rdata == '0))
    else $error("unmapped access stalled or returned nonzero data");

  ram_one_wait: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    ram_rd && i_rsp.wt |=> ram_rd && !i_rsp.wt)
    else $error("ram read did not complete after one wait cycle");

  ram_no_early: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    ram_rd && !i_rsp.wt |-> $past(ram_rd && i_rsp.wt))
    else $error("ram read completed without a wait cycle");

  req_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_rsp.wt |=> $stable(i_req))
    else $error("request changed while wait was high");

  irq_drop: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    ctrl_clr |-> ##2 !i_irq)
    else $error("irq still high one cycle after clearing write");

endmodule

bind bus_top tb_bus_asserts u_asserts (
  .i_clk    (i_clk),
  .i_arst_n (i_arst_n),
  .i_req    (i_req),
  .i_rsp    (o_rsp),
  .i_sel    (sel),
  .i_irq    (o_irq)
);

// ==== tb_clk.sv ====
//############################
// testbench clock and reset
//############################
`timescale 1ns/1ns

module tb_clk (
  output logic o_clk,
  output logic o_arst_n
);

  initial begin
    o_clk    = 1'b0;
    o_arst_n = 1'b0;
    repeat (10) @(posedge o_clk);
    // release away from the rising edge
    @(negedge o_clk);
    o_arst_n = 1'b1;
  end

  // 10 ns period
  always #5 o_clk = ~o_clk;

endmodule

// ==== bus_top.sv ====
//############################
// bus top, decoder, ram, timer,
// board i/o and response mux
//############################
`timescale 1ns/1ns

module bus_top (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  bus_pkg::bus_req_t i_req,
  output bus_pkg::bus_rsp_t o_rsp,
  output logic              o_irq,
  input  logic [15:0]       i_sw,
  output logic [15:0]       o_led
);
  import bus_pkg::*;

  dev_sel_t sel;
  bus_rsp_t ram_rsp;
  bus_rsp_t tmr_rsp;
  bus_rsp_t bio_rsp;

  bus_decode u_decode (
    .i_req (i_req),
    .o_sel (sel)
  );

  // every slave sees the shared request, its select is its enable
  ram_blk u_ram (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_sel    (sel.ram),
    .i_req    (i_req),
    .o_rsp    (ram_rsp)
  );

  tmr_blk u_tmr (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_sel    (sel.tmr),
    .i_req    (i_req),
    .o_rsp    (tmr_rsp),
    .o_irq    (o_irq)
  );

  bio_blk u_bio (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_sel    (sel.bio),
    .i_req    (i_req),
    .o_rsp    (bio_rsp),
    .i_sw     (i_sw),
    .o_led    (o_led)
  );

  bus_resp_mux u_resp_mux (
    .i_sel     (sel),
    .i_ram_rsp (ram_rsp),
    .i_tmr_rsp (tmr_rsp),
    .i_bio_rsp (bio_rsp),
    .o_rsp     (o_rsp)
  );

endmodule

// ==== bio_blk.sv ====
//############################
// board i/o, led register and
// switch input
//############################
`timescale 1ns/1ns

module bio_blk (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  logic              i_sel,
  input  bus_pkg::bus_req_t i_req,
  output bus_pkg::bus_rsp_t o_rsp,
  input  logic [15:0]       i_sw,
  output logic [15:0]       o_led
);

  logic sw_reg;

  // addr bit 2 picks the switch register, read only
  assign sw_reg = i_req.addr[2];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_led <= 16'h0000;
    end else if (i_sel && i_req.wr && !sw_reg) begin
      o_led <= i_req.wdata[15:0];
    end
  end

  assign o_rsp.rdata = sw_reg ? {16'h0000, i_sw} : {16'h0000, o_led};
  assign o_rsp.wt    = 1'b0;

endmodule

// ==== tmr_blk.sv ====
//############################
// interval timer, ctrl/div/cnt
// registers and interrupt
//############################
`timescale 1ns/1ns

module tmr_blk (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  logic              i_sel,
  input  bus_pkg::bus_req_t i_req,
  output bus_pkg::bus_rsp_t o_rsp,
  output logic              o_irq
);
  import bus_pkg::*;

  logic       irq_en;
  logic       expired;
  bus_data_t  div;
  bus_data_t  cnt;
  logic [1:0] reg_idx;
  logic       wr_ctrl;
  logic       wr_div;
  logic       tick;

  assign reg_idx = i_req.addr[3:2];
  assign wr_ctrl = i_sel && i_req.wr && (reg_idx == TMR_CTRL);
  assign wr_div  = i_sel && i_req.wr && (reg_idx == TMR_DIV);

  // counter reaches its last count this cycle
  assign tick = (div != '0) && (cnt == 32'd1) && !wr_div;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      irq_en  <= 1'b0;
      expired <= 1'b0;
      div     <= '0;
      cnt     <= '0;
      o_irq   <= 1'b0;
    end else begin
      o_irq <= expired && irq_en;

      if (wr_div) begin
        div <= i_req.wdata;
        cnt <= i_req.wdata;
      end else if (tick) begin
        cnt <= div;
      end else if (div != '0) begin
        cnt <= cnt - 32'd1;
      end

      if (tick) begin
        expired <= 1'b1;
      end
      // a clearing write wins over a coincident expiry
      if (wr_ctrl) begin
        irq_en <= i_req.wdata[0];
        if (!i_req.wdata[1]) begin
          expired <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    case (reg_idx)
      TMR_CTRL: o_rsp.rdata = {30'd0, expired, irq_en};
      TMR_DIV:  o_rsp.rdata = div;
      TMR_CNT:  o_rsp.rdata = cnt;
      default:  o_rsp.rdata = '0;
    endcase
  end

  assign o_rsp.wt = 1'b0;

endmodule

// ==== ram_blk.sv ====
//############################
// word ram with byte lane writes
// and one read wait state
//############################
`timescale 1ns/1ns

module ram_blk (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  logic              i_sel,
  input  bus_pkg::bus_req_t i_req,
  output bus_pkg::bus_rsp_t o_rsp
);
  import bus_pkg::*;

  bus_data_t         mem [RAM_WORDS];
  logic [RAM_AW-1:0] word_addr;
  logic [3:0]        lanes;
  bus_data_t         wdata_rep;
  bus_data_t         rd_q;
  ram_state_t        state;
  logic              rd_start;

  assign word_addr = i_req.addr[RAM_AW+1:2];

  // write lanes and data replicated onto them
  always_comb begin
    case (i_req.size)
      SIZE_BYTE: begin
        lanes     = 4'b0001 << i_req.addr[1:0];
        wdata_rep = {4{i_req.wdata[7:0]}};
      end
      SIZE_HALF: begin
        lanes     = i_req.addr[1] ? 4'b1100 : 4'b0011;
        wdata_rep = {2{i_req.wdata[15:0]}};
      end
      default: begin
        lanes     = 4'b1111;
        wdata_rep = i_req.wdata;
      end
    endcase
  end

  assign rd_start = i_sel && !i_req.wr && (state == RAM_IDLE);

  always_ff @(posedge i_clk) begin
    if (i_sel && i_req.wr) begin
      for (int b = 0; b < 4; b++) begin
        if (lanes[b]) begin
          mem[word_addr][8*b +: 8] <= wdata_rep[8*b +: 8];
        end
      end
    end
    if (rd_start) begin
      rd_q <= mem[word_addr];
    end
  end

  // read sequencer, one wait cycle then data
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state <= RAM_IDLE;
    end else if (state == RAM_DATA) begin
      state <= RAM_IDLE;
    end else if (rd_start) begin
      state <= RAM_DATA;
    end
  end

  assign o_rsp.rdata = rd_q;
  assign o_rsp.wt    = rd_start;

endmodule

// ==== bus_resp_mux.sv ====
//############################
// response mux, read data and
// wait of the selected device
//############################
`timescale 1ns/1ns

module bus_resp_mux (
  input  bus_pkg::dev_sel_t i_sel,
  input  bus_pkg::bus_rsp_t i_ram_rsp,
  input  bus_pkg::bus_rsp_t i_tmr_rsp,
  input  bus_pkg::bus_rsp_t i_bio_rsp,
  output bus_pkg::bus_rsp_t o_rsp
);

  // slave rdata is ungated, the select qualifies it here
  always_comb begin
    if (i_sel.ram) begin
      o_rsp = i_ram_rsp;
    end else if (i_sel.tmr) begin
      o_rsp = i_tmr_rsp;
    end else if (i_sel.bio) begin
      o_rsp = i_bio_rsp;
    end else begin
      // unmapped or idle, complete at once with zero data
      o_rsp = '0;
    end
  end

  // the decoder guarantees a one-hot or empty
  // select, so the priority order above never
  // has to break a tie

endmodule

// ==== bus_decode.sv ====
//############################
// address decoder, one-hot
// device select from cpu request
//############################
`timescale 1ns/1ns

module bus_decode (
  input  bus_pkg::bus_req_t i_req,
  output bus_pkg::dev_sel_t o_sel
);
  import bus_pkg::*;

  logic      io_en;
  bus_addr_t addr;

  assign addr = i_req.addr;

  // i/o region is the 256 MB block at 0x3000_0000
  assign io_en = i_req.en && (addr[31:28] == 4'h3);

  always_comb begin
    o_sel = '0;

    // ram occupies the low 32 MB
    if (i_req.en && (addr[31:25] == 7'b0000000)) begin
      o_sel.ram = 1'b1;
    end

    // timer 0, page 0 only
    if (io_en && (addr[31:20] == TMR_BASE_HI) && (addr[19:12] == 8'h00)) begin
      o_sel.tmr = 1'b1;
    end

    if (io_en && (addr[31:20] == BIO_BASE_HI)) begin
      o_sel.bio = 1'b1;
    end
  end

  // everything else is left unselected and
  // completes in the response mux with zero data
  // ROM at 0x2000_0000 and the other devices
  // of the full map are not present here

endmodule

// ==== bus_pkg.sv ====
//############################
// system bus address map, widths,
// request/response/select types
//############################
package bus_pkg;

  // ram geometry, aliased inside the 32 MB window
  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = 8;

  // device bases on address bits 31..20
  localparam logic [11:0] TMR_BASE_HI = 12'h300;
  localparam logic [11:0] BIO_BASE_HI = 12'h310;

  // timer register indices on addr[3:2]
  localparam logic [1:0] TMR_CTRL = 2'd0;
  localparam logic [1:0] TMR_DIV  = 2'd1;
  localparam logic [1:0] TMR_CNT  = 2'd2;

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [1:0]  bus_size_t;

  // transfer sizes
  localparam bus_size_t SIZE_BYTE = 2'd0;
  localparam bus_size_t SIZE_HALF = 2'd1;
  localparam bus_size_t SIZE_WORD = 2'd2;

  typedef struct packed {
    logic      en;
    logic      wr;
    bus_size_t size;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

  typedef struct packed {
    bus_data_t rdata;
    logic      wt;
  } bus_rsp_t;

  typedef struct packed {
    logic ram;
    logic tmr;
    logic bio;
  } dev_sel_t;

  typedef enum logic {RAM_IDLE, RAM_DATA} ram_state_t;

endpackage
